/* pixCmdDispatch.sv */
`timescale 1ns/1ps

module pixCmdDispatch
    import pixI2cCmdPkg::*;
#(
    parameter int NumBuses = 2
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        cmdValid,
    input  logic [$clog2(NumBuses)-1:0] cmdBus,
    input  slaveAddrT                   cmdSlaveAddr,
    input  logic                        cmdWrite,
    input  regAddrT                     cmdRegAddr,
    input  dataWordT                    cmdWriteData,
    input  cmdLenT                      cmdLen,
    input  logic [NumBuses-1:0]         doneVec,
    output logic [NumBuses-1:0]         busy,
    output logic                        cmdReject,
    output slaveAddrT                   busSlaveAddr [NumBuses],
    output logic [NumBuses-1:0]         busWrite,
    output regAddrT                     busRegAddr [NumBuses],
    output dataWordT                    busWriteData [NumBuses],
    output cmdLenT                      busDataLen [NumBuses]
);

    always_ff @(posedge clk) begin
        cmdReject <= 1'b0;
        if (!rstN) begin
            busy <= '0;
            for (int i = 0; i < NumBuses; i++) begin
                busDataLen[i] <= cmdLenNone;
            end
        end else begin
            // A finished bus drops its length before the master looks again
            for (int i = 0; i < NumBuses; i++) begin
                if (doneVec[i]) begin
                    busy[i] <= 1'b0;
                    busDataLen[i] <= cmdLenNone;
                end
            end
            if (cmdValid && cmdLen != cmdLenNone) begin
                // Bus indices past NumBuses are refused like a busy bus
                if (cmdBus >= NumBuses || busy[cmdBus]) begin
                    cmdReject <= 1'b1;
                end else begin
                    busy[cmdBus] <= 1'b1;
                    busSlaveAddr[cmdBus] <= cmdSlaveAddr;
                    busWrite[cmdBus] <= cmdWrite;
                    busRegAddr[cmdBus] <= cmdRegAddr;
                    busWriteData[cmdBus] <= cmdWriteData;
                    busDataLen[cmdBus] <= cmdLen;
                end
            end
        end
    end

    // Master reads its command fields throughout the transaction
    for (genvar g = 0; g < NumBuses; g++) begin : genHold
        assert property (@(posedge clk) disable iff (!rstN)
            busy[g] && !doneVec[g] |=> $stable({busSlaveAddr[g], busWrite[g],
                busRegAddr[g], busWriteData[g], busDataLen[g]}));
    end

endmodule

/* pixI2c.f */
pixI2cBusPkg.sv
pixI2cCmdPkg.sv
pixI2cMaster.sv
pixCmdDispatch.sv
pixResultCollect.sv
pixI2cTop.sv
tbI2cSlave.sv
tbPixI2c.sv

/* pixI2cBusPkg.sv */
package pixI2cBusPkg;

    // R/W bit that follows the 7-bit slave address
    localparam logic dirWrite = 1'b0;
    localparam logic dirRead = 1'b1;

    // Clock cycles in a quarter of the SCL period.
    // Both divisions round up, so the bus never runs faster than busFreq.
    function automatic logic [31:0] quarterDelay(
        input longint clkFreq,
        input longint busFreq
    );
        longint quarterNs;
        longint cycles;
        quarterNs = (64'd1_000_000_000 + 4 * busFreq - 1) / (4 * busFreq);
        cycles = (quarterNs * clkFreq + 64'd999_999_999) / 64'd1_000_000_000;
        return cycles[31:0];
    endfunction

endpackage

/* pixI2cCmdPkg.sv */
package pixI2cCmdPkg;

    // Number of data bytes in one register access
    typedef enum logic [1:0] {
        cmdLenNone = 2'd0,
        cmdLenOne  = 2'd1,
        cmdLenTwo  = 2'd2
    } cmdLenT;

    // 7-bit addressing only
    typedef logic [6:0] slaveAddrT;

    // Sensor register map uses 16-bit register addresses
    typedef logic [15:0] regAddrT;

    // Write data and read data, high byte first on the wire
    typedef logic [15:0] dataWordT;

endpackage

/* pixI2cMaster.sv */
`timescale 1ns/1ps

module pixI2cMaster
    import pixI2cBusPkg::*;
    import pixI2cCmdPkg::*;
#(
    parameter int ClkFreq = 50000000,
    parameter int I2cClkFreq = 400000
) (
    input  logic      clk,
    input  logic      rstN,
    input  slaveAddrT cmdSlaveAddr,
    input  logic      cmdWrite,
    input  regAddrT   cmdRegAddr,
    input  dataWordT  cmdWriteData,
    input  cmdLenT    cmdDataLen,
    output dataWordT  cmdReadData,
    output logic      cmdDone,
    output logic      cmdOk,
    output logic      i2cClk,
    inout  wire       i2cData
);

    localparam int QDelay = quarterDelay(ClkFreq, I2cClkFreq);
    localparam int DelayWidth = $clog2(QDelay + 1);

    localparam logic [5:0] StIdle = 6'd0;
    localparam logic [5:0] StStart = 6'd1;
    localparam logic [5:0] StShift = 6'd4;
    localparam logic [5:0] StRegAddr = 6'd11;
    localparam logic [5:0] StWrData = 6'd13;
    localparam logic [5:0] StRead = 6'd15;
    localparam logic [5:0] StAck = 6'd24;
    localparam logic [5:0] StStopOk = 6'd28;
    localparam logic [5:0] StStopFail = 6'd29;
    localparam logic [5:0] StStop = 6'd30;

    logic [5:0] state;
    logic [5:0] nextState;
    // Slave ACK seen in the shift loop, or ACK to send in StAck
    logic ack;
    // Bit 8 drives SDA, bit 0 is the sentinel
    logic [8:0] outShift;
    // Sentinel rises to bit 16 when the last byte is in
    logic [16:0] inShift;
    logic [DelayWidth-1:0] delay;
    logic sdaIn;

    // Open drain: pull low or release
    assign i2cData = outShift[8] ? 1'bz : 1'b0;
    assign sdaIn = i2cData;
    assign cmdReadData = inShift[15:0];

    always_ff @(posedge clk) begin
        cmdDone <= 1'b0;
        if (!rstN) begin
            state <= StIdle;
            nextState <= StIdle;
            ack <= 1'b0;
            outShift <= '1;
            delay <= '0;
            i2cClk <= 1'b1;
            cmdOk <= 1'b0;
        end else if (delay != '0) begin
            delay <= delay - 1'b1;
        end else begin
            // Each step holds for one quarter period unless overridden
            delay <= DelayWidth'(QDelay);
            case (state)
                StIdle: begin
                    i2cClk <= 1'b1;
                    outShift <= '1;
                    state <= StStart;
                end
                // Wait for a command, then SDA falls while SCL is high
                StStart: begin
                    if (cmdDataLen != cmdLenNone) begin
                        outShift <= '0;
                        state <= StStart + 6'd1;
                    end else begin
                        delay <= '0;
                    end
                end
                StStart + 6'd1: begin
                    i2cClk <= 1'b0;
                    state <= StStart + 6'd2;
                end
                // Reads also open with the write direction to set the register
                StStart + 6'd2: begin
                    outShift <= {cmdSlaveAddr, dirWrite, 1'b1};
                    state <= StShift;
                    nextState <= StRegAddr;
                end
                StShift: begin
                    i2cClk <= 1'b1;
                    state <= StShift + 6'd1;
                end
                StShift + 6'd1: begin
                    state <= StShift + 6'd2;
                end
                StShift + 6'd2: begin
                    i2cClk <= 1'b0;
                    state <= StShift + 6'd3;
                end
                // Next bit, or release SDA for the slave ACK
                StShift + 6'd3: begin
                    if (outShift[7:0] != 8'h80) begin
                        outShift <= outShift << 1;
                        state <= StShift;
                    end else begin
                        outShift <= '1;
                        state <= StShift + 6'd4;
                    end
                end
                StShift + 6'd4: begin
                    i2cClk <= 1'b1;
                    state <= StShift + 6'd5;
                end
                StShift + 6'd5: begin
                    ack <= !sdaIn;
                    state <= StShift + 6'd6;
                end
                StShift + 6'd6: begin
                    i2cClk <= 1'b0;
                    state <= ack ? nextState : StStopFail;
                end
                StRegAddr: begin
                    outShift <= {cmdRegAddr[15:8], 1'b1};
                    state <= StShift;
                    nextState <= StRegAddr + 6'd1;
                end
                StRegAddr + 6'd1: begin
                    outShift <= {cmdRegAddr[7:0], 1'b1};
                    state <= StShift;
                    if (!cmdWrite) begin
                        nextState <= StRead;
                    end else if (cmdDataLen == cmdLenTwo) begin
                        nextState <= StWrData;
                    end else begin
                        nextState <= StWrData + 6'd1;
                    end
                end
                StWrData: begin
                    outShift <= {cmdWriteData[15:8], 1'b1};
                    state <= StShift;
                    nextState <= StWrData + 6'd1;
                end
                StWrData + 6'd1: begin
                    outShift <= {cmdWriteData[7:0], 1'b1};
                    state <= StShift;
                    nextState <= StStopOk;
                end
                // Repeated start
                StRead: begin
                    outShift <= '1;
                    state <= StRead + 6'd1;
                end
                StRead + 6'd1: begin
                    i2cClk <= 1'b1;
                    state <= StRead + 6'd2;
                end
                StRead + 6'd2: begin
                    outShift <= '0;
                    state <= StRead + 6'd3;
                end
                StRead + 6'd3: begin
                    i2cClk <= 1'b0;
                    state <= StRead + 6'd4;
                end
                // A one-byte read starts the sentinel at bit 8 so the high byte stays zero
                StRead + 6'd4: begin
                    outShift <= {cmdSlaveAddr, dirRead, 1'b1};
                    inShift <= (cmdDataLen == cmdLenTwo) ? 17'h00001 : 17'h00100;
                    state <= StShift;
                    nextState <= StRead + 6'd5;
                end
                StRead + 6'd5: begin
                    outShift <= '1;
                    state <= StRead + 6'd6;
                end
                StRead + 6'd6: begin
                    i2cClk <= 1'b1;
                    state <= StRead + 6'd7;
                end
                StRead + 6'd7: begin
                    inShift <= {inShift[15:0], sdaIn};
                    state <= StRead + 6'd8;
                end
                StRead + 6'd8: begin
                    i2cClk <= 1'b0;
                    if (inShift[16:8] == 9'b0_0000_0001) begin
                        ack <= 1'b1;
                        nextState <= StRead + 6'd5;
                        state <= StAck;
                    end else if (inShift[16]) begin
                        // Last byte gets a NACK
                        ack <= 1'b0;
                        nextState <= StStopOk;
                        state <= StAck;
                    end else begin
                        state <= StRead + 6'd5;
                    end
                end
                StAck: begin
                    outShift <= ack ? 9'h000 : 9'h1ff;
                    state <= StAck + 6'd1;
                end
                StAck + 6'd1: begin
                    i2cClk <= 1'b1;
                    state <= StAck + 6'd2;
                end
                StAck + 6'd2: begin
                    state <= StAck + 6'd3;
                end
                StAck + 6'd3: begin
                    i2cClk <= 1'b0;
                    state <= nextState;
                end
                StStopOk: begin
                    cmdOk <= 1'b1;
                    outShift <= '0;
                    state <= StStop;
                end
                StStopFail: begin
                    cmdOk <= 1'b0;
                    outShift <= '0;
                    state <= StStop;
                end
                StStop: begin
                    i2cClk <= 1'b1;
                    state <= StStop + 6'd1;
                end
                // Stop: SDA rises while SCL is high
                StStop + 6'd1: begin
                    outShift <= '1;
                    state <= StStop + 6'd2;
                end
                StStop + 6'd2: begin
                    cmdDone <= 1'b1;
                    delay <= '0;
                    state <= StIdle;
                end
                default: begin
                    state <= StIdle;
                end
            endcase
        end
    end

    // Dispatcher clears the command on a single done
    assert property (@(posedge clk) disable iff (!rstN) cmdDone |=> !cmdDone);

    // Nothing on the bus may hold SDA high while we pull it low
    assert property (@(posedge clk) disable iff (!rstN) !outShift[8] |-> i2cData === 1'b0);

endmodule

/* pixI2cTop.sv */
`timescale 1ns/1ps

module pixI2cTop
    import pixI2cCmdPkg::*;
#(
    parameter int NumBuses = 2,
    parameter int ClkFreq = 50000000,
    parameter int I2cClkFreq = 400000
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        cmdValid,
    input  logic [$clog2(NumBuses)-1:0] cmdBus,
    input  slaveAddrT                   cmdSlaveAddr,
    input  logic                        cmdWrite,
    input  regAddrT                     cmdRegAddr,
    input  dataWordT                    cmdWriteData,
    input  cmdLenT                      cmdLen,
    output logic [NumBuses-1:0]         busy,
    output logic                        cmdReject,
    output logic                        resultValid,
    output logic [$clog2(NumBuses)-1:0] resultBus,
    output logic                        resultOk,
    output dataWordT                    resultData,
    output logic [NumBuses-1:0]         i2cClk,
    inout  wire  [NumBuses-1:0]         i2cData
);

    // Per-bus command levels from the dispatcher
    wire slaveAddrT busSlaveAddr [NumBuses];
    wire [NumBuses-1:0] busWrite;
    wire regAddrT busRegAddr [NumBuses];
    wire dataWordT busWriteData [NumBuses];
    wire cmdLenT busDataLen [NumBuses];

    // Per-bus results toward the collector
    wire [NumBuses-1:0] doneVec;
    wire [NumBuses-1:0] okVec;
    wire dataWordT readDataVec [NumBuses];

    pixCmdDispatch #(
        .NumBuses(NumBuses)
    ) uDispatch (
        .clk          (clk),
        .rstN         (rstN),
        .cmdValid     (cmdValid),
        .cmdBus       (cmdBus),
        .cmdSlaveAddr (cmdSlaveAddr),
        .cmdWrite     (cmdWrite),
        .cmdRegAddr   (cmdRegAddr),
        .cmdWriteData (cmdWriteData),
        .cmdLen       (cmdLen),
        .doneVec      (doneVec),
        .busy         (busy),
        .cmdReject    (cmdReject),
        .busSlaveAddr (busSlaveAddr),
        .busWrite     (busWrite),
        .busRegAddr   (busRegAddr),
        .busWriteData (busWriteData),
        .busDataLen   (busDataLen)
    );

    for (genvar i = 0; i < NumBuses; i++) begin : genBus
        pixI2cMaster #(
            .ClkFreq    (ClkFreq),
            .I2cClkFreq (I2cClkFreq)
        ) uMaster (
            .clk          (clk),
            .rstN         (rstN),
            .cmdSlaveAddr (busSlaveAddr[i]),
            .cmdWrite     (busWrite[i]),
            .cmdRegAddr   (busRegAddr[i]),
            .cmdWriteData (busWriteData[i]),
            .cmdDataLen   (busDataLen[i]),
            .cmdReadData  (readDataVec[i]),
            .cmdDone      (doneVec[i]),
            .cmdOk        (okVec[i]),
            .i2cClk       (i2cClk[i]),
            .i2cData      (i2cData[i])
        );
    end

    pixResultCollect #(
        .NumBuses(NumBuses)
    ) uCollect (
        .clk         (clk),
        .rstN        (rstN),
        .doneVec     (doneVec),
        .okVec       (okVec),
        .readDataVec (readDataVec),
        .resultValid (resultValid),
        .resultBus   (resultBus),
        .resultOk    (resultOk),
        .resultData  (resultData)
    );

endmodule

/* pixResultCollect.sv */
`timescale 1ns/1ps

module pixResultCollect
    import pixI2cCmdPkg::*;
#(
    parameter int NumBuses = 2
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [NumBuses-1:0]         doneVec,
    input  logic [NumBuses-1:0]         okVec,
    input  dataWordT                    readDataVec [NumBuses],
    output logic                        resultValid,
    output logic [$clog2(NumBuses)-1:0] resultBus,
    output logic                        resultOk,
    output dataWordT                    resultData
);

    localparam int BusW = $clog2(NumBuses);

    logic [NumBuses-1:0] pending;
    logic [NumBuses-1:0] slotOk;
    dataWordT slotData [NumBuses];
    // Fresh dones compete with older pending slots
    logic [NumBuses-1:0] cand;
    // Lowest set bit of cand, one-hot
    logic [NumBuses-1:0] pick;

    assign cand = pending | doneVec;
    assign pick = cand & (~cand + 1'b1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending <= '0;
            resultValid <= 1'b0;
        end else begin
            pending <= cand & ~pick;
            resultValid <= |cand;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NumBuses; i++) begin
            if (doneVec[i]) begin
                slotOk[i] <= okVec[i];
                slotData[i] <= readDataVec[i];
            end
        end
        // A bus done this cycle bypasses its slot
        for (int i = 0; i < NumBuses; i++) begin
            if (pick[i]) begin
                resultBus <= i[BusW-1:0];
                resultOk <= doneVec[i] ? okVec[i] : slotOk[i];
                resultData <= doneVec[i] ? readDataVec[i] : slotData[i];
            end
        end
    end

    // One slot per bus, so a bus must be drained before it finishes again
    assert property (@(posedge clk) disable iff (!rstN) (doneVec & pending) == '0);

endmodule

/* tbI2cSlave.sv */
`timescale 1ns/1ps

module tbI2cSlave
    import pixI2cCmdPkg::*;
#(
    parameter slaveAddrT SlaveAddr = 7'h10
) (
    input  wire scl,
    inout  wire sda
);

    logic [7:0] mem [64];
    logic sdaOut = 1'b1;
    // Between a start and a stop, or until the address is refused
    logic inFrame = 1'b0;
    // Sending bytes to the master
    logic readMode = 1'b0;
    // Address came with the read bit, turn around after its ACK
    logic readNext = 1'b0;
    // Bit position in the byte, 8 is the ACK slot, 15 waits out the start
    logic [3:0] bitCnt = 4'd0;
    logic [7:0] shiftReg = 8'h00;
    int byteIdx = 0;
    logic [5:0] ptr = 6'd0;
    logic masterAck = 1'b0;

    // Open drain, the pullup sits in the testbench
    assign sda = sdaOut ? 1'bz : 1'b0;

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 8'(i * 29 + 71);
        end
    end

    // Start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            inFrame = 1'b1;
            readMode = 1'b0;
            readNext = 1'b0;
            bitCnt = 4'hf;
            byteIdx = 0;
            sdaOut = 1'b1;
        end
    end

    // Stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            inFrame = 1'b0;
            readMode = 1'b0;
            sdaOut = 1'b1;
        end
    end

    always @(posedge scl) begin
        if (inFrame) begin
            if (bitCnt < 4'd8 && !readMode) begin
                shiftReg = {shiftReg[6:0], sda === 1'b1};
            end else if (bitCnt == 4'd8 && readMode) begin
                masterAck = (sda === 1'b0);
            end
        end
    end

    // All SDA changes from the slave happen while SCL is low
    always @(negedge scl) begin
        if (inFrame) begin
            if (bitCnt == 4'hf) begin
                bitCnt = 4'd0;
            end else if (bitCnt < 4'd7) begin
                bitCnt = bitCnt + 4'd1;
                if (readMode) begin
                    sdaOut = shiftReg[3'(4'd7 - bitCnt)];
                end
            end else if (bitCnt == 4'd7) begin
                bitCnt = 4'd8;
                if (readMode) begin
                    // Master drives its ACK now
                    sdaOut = 1'b1;
                end else if (byteIdx == 0 && shiftReg[7:1] != SlaveAddr) begin
                    // Not our address, stay quiet until the next start
                    inFrame = 1'b0;
                end else begin
                    if (byteIdx == 0) begin
                        readNext = shiftReg[0];
                    end else if (byteIdx == 2) begin
                        ptr = shiftReg[5:0];
                    end else if (byteIdx > 2) begin
                        mem[ptr] = shiftReg;
                        ptr = ptr + 6'd1;
                    end
                    byteIdx++;
                    sdaOut = 1'b0;
                end
            end else begin
                bitCnt = 4'd0;
                sdaOut = 1'b1;
                if (readNext || (readMode && masterAck)) begin
                    readNext = 1'b0;
                    readMode = 1'b1;
                    shiftReg = mem[ptr];
                    ptr = ptr + 6'd1;
                    sdaOut = shiftReg[7];
                end else if (readMode) begin
                    // NACK from the master ends the read
                    inFrame = 1'b0;
                end
            end
        end
    end

endmodule

/* tbPixI2c.sv */
`timescale 1ns/1ps

module tbPixI2c
    import pixI2cCmdPkg::*;
();

    localparam int NumBuses = 3;
    localparam int BusW = $clog2(NumBuses);
    // Roughly 3000 cycles per register access at Q = 13
    localparam int TxnCycles = 3000;
    localparam int MaxCycles = 2 * 10 * TxnCycles;
    localparam int ResultWait = 2 * TxnCycles;
    // Long enough for a wrongly accepted command to run to its result
    localparam int QuietCycles = ResultWait;

    localparam slaveAddrT Addr0 = 7'h1a;
    localparam slaveAddrT Addr1 = 7'h36;
    localparam slaveAddrT Addr2 = 7'h48;

    localparam regAddrT TwoByteReg = 16'h3004;
    localparam regAddrT OneByteReg = 16'h0120;
    localparam regAddrT WrongReg = 16'h0208;
    localparam regAddrT ConcReg = 16'h1130;

    logic clk;
    logic rstN;
    logic cmdValid;
    logic [BusW-1:0] cmdBus;
    slaveAddrT cmdSlaveAddr;
    logic cmdWrite;
    regAddrT cmdRegAddr;
    dataWordT cmdWriteData;
    cmdLenT cmdLen;
    logic [NumBuses-1:0] busy;
    logic cmdReject;
    logic resultValid;
    logic [BusW-1:0] resultBus;
    logic resultOk;
    dataWordT resultData;
    logic [NumBuses-1:0] i2cClk;
    wire [NumBuses-1:0] i2cData;

    int seed = 44;
    int cycleCount = 0;
    int testErrors = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    dataWordT twoByteWord;

    pixI2cTop #(
        .NumBuses   (NumBuses),
        .ClkFreq    (50000000),
        .I2cClkFreq (1000000)
    ) u_dut (
        .clk          (clk),
        .rstN         (rstN),
        .cmdValid     (cmdValid),
        .cmdBus       (cmdBus),
        .cmdSlaveAddr (cmdSlaveAddr),
        .cmdWrite     (cmdWrite),
        .cmdRegAddr   (cmdRegAddr),
        .cmdWriteData (cmdWriteData),
        .cmdLen       (cmdLen),
        .busy         (busy),
        .cmdReject    (cmdReject),
        .resultValid  (resultValid),
        .resultBus    (resultBus),
        .resultOk     (resultOk),
        .resultData   (resultData),
        .i2cClk       (i2cClk),
        .i2cData      (i2cData)
    );

    for (genvar g = 0; g < NumBuses; g++) begin : genBusModel
        localparam slaveAddrT BusAddr = (g == 0) ? Addr0 : ((g == 1) ? Addr1 : Addr2);
        pullup (i2cData[g]);
        tbI2cSlave #(
            .SlaveAddr(BusAddr)
        ) uSlave (
            .scl (i2cClk[g]),
            .sda (i2cData[g])
        );
    end

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout after %0d cycles, a test never finished", cycleCount);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic slaveAddrT slaveAddrOf(input int bus);
        case (bus)
            0: return Addr0;
            1: return Addr1;
            default: return Addr2;
        endcase
    endfunction

    // Power-up contents of every sensor model register
    function automatic logic [7:0] fillByte(input regAddrT reg16);
        int idx;
        idx = int'(reg16[5:0]);
        return 8'(idx * 29 + 71);
    endfunction

    task automatic mismatch(input string testName, input string what,
                            input logic [31:0] expVal, input logic [31:0] actVal);
        $display("ERROR %s: %s expected %0h, actual %0h", testName, what, expVal, actVal);
        testErrors++;
    endtask

    task automatic finishTest(input string testName);
        if (testErrors == 0) begin
            testsPassed++;
            $display("%s: passed", testName);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", testName, testErrors);
        end
        testErrors = 0;
    endtask

    // Called on a falling edge, returns one falling edge later
    task automatic sendCmd(input int bus, input logic wr, input slaveAddrT slaveAddr,
                           input regAddrT regAddr, input dataWordT wrData, input cmdLenT len);
        cmdValid = 1'b1;
        cmdBus = BusW'(bus);
        cmdWrite = wr;
        cmdSlaveAddr = slaveAddr;
        cmdRegAddr = regAddr;
        cmdWriteData = wrData;
        cmdLen = len;
        @(negedge clk);
        cmdValid = 1'b0;
    endtask

    task automatic awaitResult(input string testName, output logic seen,
                               output logic [BusW-1:0] bus, output logic ok,
                               output dataWordT data);
        int waited;
        waited = 0;
        seen = 1'b0;
        bus = 'x;
        ok = 1'bx;
        data = 'x;
        while (!seen && waited < ResultWait) begin
            @(negedge clk);
            waited++;
            if (resultValid === 1'b1) begin
                seen = 1'b1;
                bus = resultBus;
                ok = resultOk;
                data = resultData;
            end
        end
        if (!seen) begin
            $display("%s: no result arrived within %0d cycles", testName, ResultWait);
            testErrors++;
        end
    endtask

    task automatic expectResult(input string testName, input int expBus, input logic expOk,
                                input logic checkData, input dataWordT expData);
        logic seen;
        logic [BusW-1:0] bus;
        logic ok;
        dataWordT data;
        awaitResult(testName, seen, bus, ok, data);
        if (seen) begin
            if (bus !== BusW'(expBus)) mismatch(testName, "resultBus", expBus, bus);
            if (ok !== expOk) mismatch(testName, "resultOk", expOk, ok);
            if (checkData && data !== expData) mismatch(testName, "resultData", expData, data);
        end
    endtask

    task automatic testResetState();
        if (busy !== '0) mismatch("resetState", "busy", 0, busy);
        if (resultValid !== 1'b0) mismatch("resetState", "resultValid", 0, resultValid);
        if (cmdReject !== 1'b0) mismatch("resetState", "cmdReject", 0, cmdReject);
        if (i2cClk !== '1) mismatch("resetState", "i2cClk", 3'b111, i2cClk);
        if (i2cData !== '1) mismatch("resetState", "i2cData", 3'b111, i2cData);
        finishTest("resetState");
    endtask

    task automatic testTwoByteAccess();
        twoByteWord = dataWordT'($random(seed));
        sendCmd(0, 1'b1, Addr0, TwoByteReg, twoByteWord, cmdLenTwo);
        expectResult("twoByteAccess", 0, 1'b1, 1'b0, '0);
        sendCmd(0, 1'b0, Addr0, TwoByteReg, '0, cmdLenTwo);
        expectResult("twoByteAccess", 0, 1'b1, 1'b1, twoByteWord);
        finishTest("twoByteAccess");
    endtask

    task automatic testOneByteAccess();
        logic [7:0] byteVal;
        byteVal = 8'($random(seed));
        sendCmd(1, 1'b1, Addr1, OneByteReg, {8'hff, byteVal}, cmdLenOne);
        expectResult("oneByteAccess", 1, 1'b1, 1'b0, '0);
        sendCmd(1, 1'b0, Addr1, OneByteReg, '0, cmdLenOne);
        expectResult("oneByteAccess", 1, 1'b1, 1'b1, {8'h00, byteVal});
        // Next register must still hold its power-up value
        sendCmd(1, 1'b0, Addr1, OneByteReg, '0, cmdLenTwo);
        expectResult("oneByteAccess", 1, 1'b1, 1'b1, {byteVal, fillByte(OneByteReg + 1)});
        finishTest("oneByteAccess");
    endtask

    task automatic testWrongAddress();
        dataWordT word;
        word = dataWordT'($random(seed));
        sendCmd(2, 1'b1, Addr2 ^ 7'h01, WrongReg, word, cmdLenTwo);
        expectResult("wrongAddress", 2, 1'b0, 1'b0, '0);
        sendCmd(2, 1'b0, Addr2, WrongReg, '0, cmdLenTwo);
        expectResult("wrongAddress", 2, 1'b1, 1'b1,
                     {fillByte(WrongReg), fillByte(WrongReg + 1)});
        finishTest("wrongAddress");
    endtask

    // Writes on all buses at once, then reads back at once
    task automatic testConcurrent();
        dataWordT words [NumBuses];
        int count [NumBuses];
        logic seen;
        logic [BusW-1:0] bus;
        logic ok;
        dataWordT data;
        for (int i = 0; i < NumBuses; i++) begin
            words[i] = dataWordT'($random(seed));
        end
        for (int phase = 0; phase < 2; phase++) begin
            for (int i = 0; i < NumBuses; i++) begin
                count[i] = 0;
                sendCmd(i, phase == 0, slaveAddrOf(i), ConcReg + regAddrT'(2 * i),
                        words[i], cmdLenTwo);
            end
            repeat (NumBuses) begin
                awaitResult("concurrent", seen, bus, ok, data);
                if (seen && bus < NumBuses) begin
                    count[bus]++;
                    if (ok !== 1'b1) mismatch("concurrent", "resultOk", 1, ok);
                    if (phase == 1 && data !== words[bus]) begin
                        mismatch("concurrent", "resultData", words[bus], data);
                    end
                end else if (seen) begin
                    $display("concurrent: result names bus %0d, which does not exist", bus);
                    testErrors++;
                end
            end
            for (int i = 0; i < NumBuses; i++) begin
                if (count[i] != 1) mismatch("concurrent", "results for one bus", 1, count[i]);
            end
        end
        finishTest("concurrent");
    endtask

    task automatic testBusyReject();
        logic extraSeen;
        extraSeen = 1'b0;
        sendCmd(0, 1'b0, Addr0, TwoByteReg, '0, cmdLenTwo);
        if (busy[0] !== 1'b1) mismatch("busyReject", "busy[0]", 1, busy[0]);
        if (cmdReject !== 1'b0) mismatch("busyReject", "cmdReject", 0, cmdReject);
        sendCmd(0, 1'b1, Addr0, TwoByteReg, ~twoByteWord, cmdLenOne);
        if (cmdReject !== 1'b1) mismatch("busyReject", "cmdReject", 1, cmdReject);
        @(negedge clk);
        if (cmdReject !== 1'b0) mismatch("busyReject", "cmdReject after pulse", 0, cmdReject);
        expectResult("busyReject", 0, 1'b1, 1'b1, twoByteWord);
        repeat (QuietCycles) begin
            @(negedge clk);
            if (resultValid !== 1'b0) extraSeen = 1'b1;
        end
        if (extraSeen) begin
            $display("busyReject: the rejected command still produced a result");
            testErrors++;
        end
        if (busy !== '0) mismatch("busyReject", "busy", 0, busy);
        finishTest("busyReject");
    endtask

    initial begin
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmdBus = '0;
        cmdSlaveAddr = '0;
        cmdWrite = 1'b0;
        cmdRegAddr = '0;
        cmdWriteData = '0;
        cmdLen = cmdLenNone;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        testResetState();
        testTwoByteAccess();
        testOneByteAccess();
        testWrongAddress();
        testConcurrent();
        testBusyReject();
        $display("%0d tests passed, %0d tests failed", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
